/* hdl/gpu_pkg.sv */
package gpu_pkg;

        //////////////////////////////
        // data and address widths
        //////////////////////////////
        typedef logic [31:0] addr_t;
        typedef logic [31:0] word_t;
        typedef logic [15:0] len_t;
        typedef logic [2:0]  reg_addr_t;

        // byte step between consecutive words
        localparam addr_t WORD_BYTES = 32'd4;

        // fifo sizing, free count must hold the full depth
        localparam int FIFO_CNT_W = 4;
        localparam logic [FIFO_CNT_W-1:0] FIFO_DEPTH = 4'd8;

        //////////////////////////////
        // register map
        //////////////////////////////
        localparam reg_addr_t REG_CTRL   = 3'd0;
        localparam reg_addr_t REG_SRC    = 3'd1;
        localparam reg_addr_t REG_DST    = 3'd2;
        localparam reg_addr_t REG_LEN    = 3'd3;
        localparam reg_addr_t REG_STATUS = 3'd4;

        // copy sequencer states
        typedef enum logic [1:0] {
                COPY_IDLE,
                COPY_RUN,
                COPY_DONE
        } copy_state_t;

endpackage

/* hdl/gpu_controller.sv */
`timescale 1ns/1ps

module gpu_controller (
        input  logic               i_wire_clock,
        input  logic               i_rst,
        input  logic               i_reg_write,
        input  gpu_pkg::reg_addr_t i_reg_addr,
        input  gpu_pkg::word_t     i_reg_wdata,
        input  logic               i_busy,
        input  logic               i_done,
        output gpu_pkg::word_t     o_reg_rdata,
        output logic               o_start,
        output gpu_pkg::addr_t     o_src,
        output gpu_pkg::addr_t     o_dst,
        output gpu_pkg::len_t      o_len
);

        logic done_flag;

        //////////////////////////////
        // job registers
        //////////////////////////////
        always_ff @(posedge i_wire_clock) begin
                if (i_reg_write) begin
                        case (i_reg_addr)
                                gpu_pkg::REG_SRC: o_src <= i_reg_wdata;
                                gpu_pkg::REG_DST: o_dst <= i_reg_wdata;
                                gpu_pkg::REG_LEN: o_len <= i_reg_wdata[15:0];
                                default: ;
                        endcase
                end
        end

        // start pulse, a running copy swallows new requests
        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        o_start <= 1'b0;
                end else begin
                        o_start <= i_reg_write && (i_reg_addr == gpu_pkg::REG_CTRL) &&
                                   i_reg_wdata[0] && !i_busy;
                end
        end

        // sticky done, cleared by the next job
        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        done_flag <= 1'b0;
                end else if (o_start) begin
                        done_flag <= 1'b0;
                end else if (i_done) begin
                        done_flag <= 1'b1;
                end
        end

        //////////////////////////////
        // readback
        //////////////////////////////
        always_comb begin
                case (i_reg_addr)
                        gpu_pkg::REG_SRC:    o_reg_rdata = o_src;
                        gpu_pkg::REG_DST:    o_reg_rdata = o_dst;
                        gpu_pkg::REG_LEN:    o_reg_rdata = {16'd0, o_len};
                        gpu_pkg::REG_STATUS: o_reg_rdata = {30'd0, done_flag, i_busy};
                        default:             o_reg_rdata = '0;
                endcase
        end

endmodule

/* hdl/gpu_memcpy.sv */
`timescale 1ns/1ps

module gpu_memcpy (
        input  logic           i_wire_clock,
        input  logic           i_rst,
        input  logic           i_start,
        input  gpu_pkg::addr_t i_src,
        input  gpu_pkg::addr_t i_dst,
        input  gpu_pkg::len_t  i_len,
        input  logic           i_wr_done,
        output logic           o_busy,
        output logic           o_done,
        output logic           o_rd_start,
        output logic           o_wr_start,
        output gpu_pkg::addr_t o_rd_base,
        output gpu_pkg::addr_t o_wr_base,
        output gpu_pkg::len_t  o_count
);

        gpu_pkg::copy_state_t state;

        assign o_busy = (state != gpu_pkg::COPY_IDLE);

        // job latch, only taken from idle
        always_ff @(posedge i_wire_clock) begin
                if ((state == gpu_pkg::COPY_IDLE) && i_start) begin
                        o_rd_base <= i_src;
                        o_wr_base <= i_dst;
                        o_count   <= i_len;
                end
        end

        //////////////////////////////
        // sequencer
        //////////////////////////////
        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        state      <= gpu_pkg::COPY_IDLE;
                        o_done     <= 1'b0;
                        o_rd_start <= 1'b0;
                        o_wr_start <= 1'b0;
                end else begin
                        o_done     <= 1'b0;
                        o_rd_start <= 1'b0;
                        o_wr_start <= 1'b0;
                        case (state)
                                gpu_pkg::COPY_IDLE: begin
                                        if (i_start) begin
                                                // empty jobs never touch memory
                                                o_rd_start <= (i_len != '0);
                                                o_wr_start <= (i_len != '0);
                                                state      <= gpu_pkg::COPY_RUN;
                                        end
                                end
                                gpu_pkg::COPY_RUN: begin
                                        if ((o_count == '0) || i_wr_done) begin
                                                state <= gpu_pkg::COPY_DONE;
                                        end
                                end
                                default: begin
                                        o_done <= 1'b1;
                                        state  <= gpu_pkg::COPY_IDLE;
                                end
                        endcase
                end
        end

endmodule

/* hdl/gpu_dma_reader.sv */
`timescale 1ns/1ps

module gpu_dma_reader (
        input  logic                           i_wire_clock,
        input  logic                           i_rst,
        input  logic                           i_start,
        input  gpu_pkg::addr_t                 i_base,
        input  gpu_pkg::len_t                  i_count,
        input  logic [gpu_pkg::FIFO_CNT_W-1:0] i_fifo_free,
        input  logic                           i_mem_rd_valid,
        input  gpu_pkg::word_t                 i_mem_rd_data,
        output logic                           o_mem_rd_req,
        output gpu_pkg::addr_t                 o_mem_rd_addr,
        output logic                           o_push,
        output gpu_pkg::word_t                 o_push_data
);

        gpu_pkg::addr_t                 rd_addr;
        gpu_pkg::len_t                  remaining;
        logic [gpu_pkg::FIFO_CNT_W-1:0] in_flight;

        // every read in flight already owns a fifo slot
        assign o_mem_rd_req  = (remaining != '0) && (in_flight < i_fifo_free);
        assign o_mem_rd_addr = rd_addr;

        // returned words go straight into the fifo
        assign o_push      = i_mem_rd_valid;
        assign o_push_data = i_mem_rd_data;

        always_ff @(posedge i_wire_clock) begin
                if (i_start) begin
                        rd_addr <= i_base;
                end else if (o_mem_rd_req) begin
                        rd_addr <= rd_addr + gpu_pkg::WORD_BYTES;
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        remaining <= '0;
                        in_flight <= '0;
                end else begin
                        if (i_start) begin
                                remaining <= i_count;
                        end else if (o_mem_rd_req) begin
                                remaining <= remaining - 1'b1;
                        end
                        case ({o_mem_rd_req, i_mem_rd_valid})
                                2'b10:   in_flight <= in_flight + 1'b1;
                                2'b01:   in_flight <= in_flight - 1'b1;
                                default: in_flight <= in_flight;
                        endcase
                end
        end

endmodule

/* hdl/gpu_fifo.sv */
`timescale 1ns/1ps

module gpu_fifo (
        input  logic                           i_wire_clock,
        input  logic                           i_rst,
        input  logic                           i_push,
        input  gpu_pkg::word_t                 i_push_data,
        input  logic                           i_pop,
        output gpu_pkg::word_t                 o_pop_data,
        output logic                           o_empty,
        output logic [gpu_pkg::FIFO_CNT_W-1:0] o_free
);

        gpu_pkg::word_t                          mem [gpu_pkg::FIFO_DEPTH];
        logic [$clog2(gpu_pkg::FIFO_DEPTH)-1:0]  wr_ptr;
        logic [$clog2(gpu_pkg::FIFO_DEPTH)-1:0]  rd_ptr;
        logic [gpu_pkg::FIFO_CNT_W-1:0]          count;

        // head word visible without a pop
        assign o_pop_data = mem[rd_ptr];
        assign o_empty    = (count == '0);
        assign o_free     = gpu_pkg::FIFO_DEPTH - count;

        //////////////////////////////
        // storage
        //////////////////////////////
        always_ff @(posedge i_wire_clock) begin
                if (i_push) begin
                        mem[wr_ptr] <= i_push_data;
                end
        end

        //////////////////////////////
        // pointers and occupancy
        //////////////////////////////
        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (i_push) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (i_pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        // simultaneous push and pop leaves the count alone
                        case ({i_push, i_pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

endmodule

/* hdl/gpu_dma_writer.sv */
`timescale 1ns/1ps

module gpu_dma_writer (
        input  logic           i_wire_clock,
        input  logic           i_rst,
        input  logic           i_start,
        input  gpu_pkg::addr_t i_base,
        input  gpu_pkg::len_t  i_count,
        input  logic           i_empty,
        input  gpu_pkg::word_t i_data,
        input  logic           i_mem_wr_ready,
        output logic           o_pop,
        output logic           o_mem_wr_en,
        output gpu_pkg::addr_t o_mem_wr_addr,
        output gpu_pkg::word_t o_mem_wr_data,
        output logic           o_done
);

        gpu_pkg::addr_t wr_addr;
        gpu_pkg::len_t  remaining;

        // fifo head stays put until popped, so the write holds steady
        assign o_mem_wr_en   = (remaining != '0) && !i_empty;
        assign o_mem_wr_addr = wr_addr;
        assign o_mem_wr_data = i_data;
        assign o_pop         = o_mem_wr_en && i_mem_wr_ready;

        always_ff @(posedge i_wire_clock) begin
                if (i_start) begin
                        wr_addr <= i_base;
                end else if (o_pop) begin
                        wr_addr <= wr_addr + gpu_pkg::WORD_BYTES;
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        remaining <= '0;
                        o_done    <= 1'b0;
                end else if (i_start) begin
                        remaining <= i_count;
                        o_done    <= (i_count == '0);
                end else begin
                        // last accepted word ends the transfer
                        if (o_pop) begin
                                remaining <= remaining - 1'b1;
                        end
                        o_done <= o_pop && (remaining == 16'd1);
                end
        end

endmodule

/* hdl/gpu_top.sv */
`timescale 1ns/1ps

module gpu_top (
        input  logic               i_wire_clock,
        input  logic               i_rst,
        input  logic               i_reg_write,
        input  gpu_pkg::reg_addr_t i_reg_addr,
        input  gpu_pkg::word_t     i_reg_wdata,
        output gpu_pkg::word_t     o_reg_rdata,
        output logic               o_mem_rd_req,
        output gpu_pkg::addr_t     o_mem_rd_addr,
        input  logic               i_mem_rd_valid,
        input  gpu_pkg::word_t     i_mem_rd_data,
        output logic               o_mem_wr_en,
        output gpu_pkg::addr_t     o_mem_wr_addr,
        output gpu_pkg::word_t     o_mem_wr_data,
        input  logic               i_mem_wr_ready,
        output logic               o_busy,
        output logic               o_done
);

        //////////////////////////////
        // controller to sequencer
        //////////////////////////////
        logic           start;
        gpu_pkg::addr_t src;
        gpu_pkg::addr_t dst;
        gpu_pkg::len_t  len;

        // sequencer to dma engines
        logic           rd_start;
        logic           wr_start;
        gpu_pkg::addr_t rd_base;
        gpu_pkg::addr_t wr_base;
        gpu_pkg::len_t  count;
        logic           wr_done;

        // fifo path
        logic                           push;
        gpu_pkg::word_t                 push_data;
        logic                           pop;
        gpu_pkg::word_t                 pop_data;
        logic                           fifo_empty;
        logic [gpu_pkg::FIFO_CNT_W-1:0] fifo_free;

        gpu_controller u_controller (
                .i_wire_clock (i_wire_clock),
                .i_rst        (i_rst),
                .i_reg_write  (i_reg_write),
                .i_reg_addr   (i_reg_addr),
                .i_reg_wdata  (i_reg_wdata),
                .i_busy       (o_busy),
                .i_done       (o_done),
                .o_reg_rdata  (o_reg_rdata),
                .o_start      (start),
                .o_src        (src),
                .o_dst        (dst),
                .o_len        (len)
        );

        gpu_memcpy u_memcpy (
                .i_wire_clock (i_wire_clock),
                .i_rst        (i_rst),
                .i_start      (start),
                .i_src        (src),
                .i_dst        (dst),
                .i_len        (len),
                .i_wr_done    (wr_done),
                .o_busy       (o_busy),
                .o_done       (o_done),
                .o_rd_start   (rd_start),
                .o_wr_start   (wr_start),
                .o_rd_base    (rd_base),
                .o_wr_base    (wr_base),
                .o_count      (count)
        );

        gpu_dma_reader u_reader (
                .i_wire_clock   (i_wire_clock),
                .i_rst          (i_rst),
                .i_start        (rd_start),
                .i_base         (rd_base),
                .i_count        (count),
                .i_fifo_free    (fifo_free),
                .i_mem_rd_valid (i_mem_rd_valid),
                .i_mem_rd_data  (i_mem_rd_data),
                .o_mem_rd_req   (o_mem_rd_req),
                .o_mem_rd_addr  (o_mem_rd_addr),
                .o_push         (push),
                .o_push_data    (push_data)
        );

        gpu_fifo u_fifo (
                .i_wire_clock (i_wire_clock),
                .i_rst        (i_rst),
                .i_push       (push),
                .i_push_data  (push_data),
                .i_pop        (pop),
                .o_pop_data   (pop_data),
                .o_empty      (fifo_empty),
                .o_free       (fifo_free)
        );

        gpu_dma_writer u_writer (
                .i_wire_clock   (i_wire_clock),
                .i_rst          (i_rst),
                .i_start        (wr_start),
                .i_base         (wr_base),
                .i_count        (count),
                .i_empty        (fifo_empty),
                .i_data         (pop_data),
                .i_mem_wr_ready (i_mem_wr_ready),
                .o_pop          (pop),
                .o_mem_wr_en    (o_mem_wr_en),
                .o_mem_wr_addr  (o_mem_wr_addr),
                .o_mem_wr_data  (o_mem_wr_data),
                .o_done         (wr_done)
        );

endmodule

/* verif/gpu_properties.sv */
`timescale 1ns/1ps

module gpu_properties (
        input logic           i_wire_clock,
        input logic           i_rst,
        input logic           i_busy,
        input logic           i_mem_rd_req,
        input logic           i_mem_rd_valid,
        input logic           i_mem_wr_en,
        input logic           i_mem_wr_ready,
        input gpu_pkg::addr_t i_mem_wr_addr,
        input gpu_pkg::word_t i_mem_wr_data
);

        int fail_count = 0;
        int outstanding;
        int held;

        // reads requested but not answered yet, and answered words not yet written
        always_ff @(posedge i_wire_clock) begin
                if (i_rst) begin
                        outstanding <= 0;
                        held        <= 0;
                end else begin
                        outstanding <= outstanding + int'(i_mem_rd_req) - int'(i_mem_rd_valid);
                        held        <= held + int'(i_mem_rd_valid) -
                                       int'(i_mem_wr_en && i_mem_wr_ready);
                end
        end

        //////////////////////////////
        // memory port rules
        //////////////////////////////
        wr_hold: assert property (@(posedge i_wire_clock) disable iff (i_rst)
                i_mem_wr_en && !i_mem_wr_ready |=>
                        i_mem_wr_en && $stable(i_mem_wr_addr) && $stable(i_mem_wr_data))
                else begin
                        fail_count++;
                        $error("write port changed while stalled");
                end

        // in flight reads plus buffered words must fit in the fifo
        rd_window: assert property (@(posedge i_wire_clock) disable iff (i_rst)
                (outstanding + held) <= int'(gpu_pkg::FIFO_DEPTH))
                else begin
                        fail_count++;
                        $error("more reads in flight than free FIFO entries");
                end

        // no traffic outside a copy
        traffic_busy: assert property (@(posedge i_wire_clock) disable iff (i_rst)
                (i_mem_rd_req || i_mem_wr_en) |-> i_busy)
                else begin
                        fail_count++;
                        $error("memory traffic while the engine is idle");
                end

endmodule

/* verif/tb_gpu.sv */
`timescale 1ns/1ps

module tb_gpu;

        // three copies of at most 13 words finish in a few hundred cycles
        localparam int MAX_CYCLES = 3000;
        localparam int MEM_WORDS  = 256;

        logic               i_wire_clock = 1'b0;
        logic               i_rst;
        logic               i_reg_write;
        gpu_pkg::reg_addr_t i_reg_addr;
        gpu_pkg::word_t     i_reg_wdata;
        gpu_pkg::word_t     o_reg_rdata;
        logic               o_mem_rd_req;
        gpu_pkg::addr_t     o_mem_rd_addr;
        logic               i_mem_rd_valid = 1'b0;
        gpu_pkg::word_t     i_mem_rd_data  = '0;
        logic               o_mem_wr_en;
        gpu_pkg::addr_t     o_mem_wr_addr;
        gpu_pkg::word_t     o_mem_wr_data;
        logic               i_mem_wr_ready = 1'b0;
        logic               o_busy;
        logic               o_done;

        gpu_pkg::word_t mem [MEM_WORDS];
        gpu_pkg::word_t rsp_data [$];
        int             rsp_due [$];
        int             mem_cycle = 0;
        int             last_due  = -1;

        // current job as seen by the memory model
        string          test_name = "reset";
        gpu_pkg::addr_t cur_src   = '0;
        gpu_pkg::addr_t cur_dst   = '0;
        int             cur_len   = 0;
        int             rd_count  = 0;
        int             wr_count  = 0;
        int             errors    = 0;

        logic ctrl_go;

        assign ctrl_go = i_reg_write && (i_reg_addr == gpu_pkg::REG_CTRL) && i_reg_wdata[0];

        gpu_top DUT (.*);

        bind gpu_top gpu_properties u_properties (
                .i_wire_clock   (i_wire_clock),
                .i_rst          (i_rst),
                .i_busy         (o_busy),
                .i_mem_rd_req   (o_mem_rd_req),
                .i_mem_rd_valid (i_mem_rd_valid),
                .i_mem_wr_en    (o_mem_wr_en),
                .i_mem_wr_ready (i_mem_wr_ready),
                .i_mem_wr_addr  (o_mem_wr_addr),
                .i_mem_wr_data  (o_mem_wr_data)
        );

        always #5 i_wire_clock = ~i_wire_clock;

        function automatic gpu_pkg::word_t fill_word(input int idx);
                return {~idx[15:0], idx[15:0]};
        endfunction

        task automatic check_value(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
                assert (act === exp) else begin
                        errors++;
                        $display("FAILED %s: expected %h, got %h", name, exp, act);
                end
        endtask

        task automatic finish_run(input bit timed_out);
                int prop_errors;
                prop_errors = DUT.u_properties.fail_count;
                $display("error count: %0d testbench, %0d protocol", errors, prop_errors);
                if (!timed_out && (errors == 0) && (prop_errors == 0)) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        endtask

        //////////////////////////////
        // memory model
        //////////////////////////////
        always @(posedge i_wire_clock) begin : mem_model
                int lat;
                int due;
                mem_cycle++;
                if (i_rst) begin
                        i_mem_rd_valid <= 1'b0;
                        i_mem_wr_ready <= 1'b0;
                end else begin
                        if (o_mem_rd_req) begin
                                assert (rd_count < cur_len) else begin
                                        errors++;
                                        $display("%s: read of %h beyond the copy length",
                                                 test_name, o_mem_rd_addr);
                                end
                                check_value({test_name, " rd_addr"},
                                            cur_src + gpu_pkg::addr_t'(rd_count) * 4,
                                            o_mem_rd_addr);
                                // answers stay in order even with random latency
                                lat = $urandom_range(1, 4);
                                due = mem_cycle + lat - 1;
                                if (due <= last_due) begin
                                        due = last_due + 1;
                                end
                                last_due = due;
                                rsp_data.push_back(mem[o_mem_rd_addr[9:2]]);
                                rsp_due.push_back(due);
                                rd_count++;
                        end
                        if ((rsp_due.size() != 0) && (rsp_due[0] <= mem_cycle)) begin
                                i_mem_rd_valid <= 1'b1;
                                i_mem_rd_data  <= rsp_data.pop_front();
                                void'(rsp_due.pop_front());
                        end else begin
                                i_mem_rd_valid <= 1'b0;
                        end
                        if (o_mem_wr_en && i_mem_wr_ready) begin
                                assert (wr_count < cur_len) else begin
                                        errors++;
                                        $display("%s: write to %h outside the destination",
                                                 test_name, o_mem_wr_addr);
                                end
                                check_value({test_name, " wr_addr"},
                                            cur_dst + gpu_pkg::addr_t'(wr_count) * 4,
                                            o_mem_wr_addr);
                                mem[o_mem_wr_addr[9:2]] = o_mem_wr_data;
                                wr_count++;
                        end
                        // stall the write side about a third of the time
                        i_mem_wr_ready <= ($urandom_range(0, 2) != 0);
                end
        end

        //////////////////////////////
        // timing rules
        //////////////////////////////
        assert property (@(posedge i_wire_clock) disable iff (i_rst) o_done |=> !o_done)
                else begin
                        errors++;
                        $display("o_done stayed high for more than one cycle");
                end

        assert property (@(posedge i_wire_clock) disable iff (i_rst) o_done == $fell(o_busy))
                else begin
                        errors++;
                        $display("o_done did not line up with the fall of o_busy");
                end

        // busy follows an accepted start two cycles later, and nothing else raises it
        assert property (@(posedge i_wire_clock) disable iff (i_rst)
                $rose(o_busy) == $past(ctrl_go && !o_busy, 2))
                else begin
                        errors++;
                        $display("o_busy did not rise two cycles after the start write");
                end

        //////////////////////////////
        // register access and copies
        //////////////////////////////
        task automatic write_reg(input gpu_pkg::reg_addr_t addr, input gpu_pkg::word_t data);
                @(posedge i_wire_clock);
                i_reg_write <= 1'b1;
                i_reg_addr  <= addr;
                i_reg_wdata <= data;
                @(posedge i_wire_clock);
                i_reg_write <= 1'b0;
        endtask

        task automatic check_reg(input string name, input gpu_pkg::reg_addr_t addr,
                                 input gpu_pkg::word_t exp);
                @(posedge i_wire_clock);
                i_reg_addr <= addr;
                @(negedge i_wire_clock);
                check_value(name, exp, o_reg_rdata);
        endtask

        task automatic run_copy(input string name, input gpu_pkg::addr_t src,
                                input gpu_pkg::addr_t dst, input gpu_pkg::len_t len,
                                input bit restart);
                int cycles;
                int src_idx;
                int dst_idx;
                test_name = name;
                write_reg(gpu_pkg::REG_SRC, src);
                write_reg(gpu_pkg::REG_DST, dst);
                write_reg(gpu_pkg::REG_LEN, {16'd0, len});
                check_reg({name, " src"}, gpu_pkg::REG_SRC, src);
                check_reg({name, " dst"}, gpu_pkg::REG_DST, dst);
                check_reg({name, " len"}, gpu_pkg::REG_LEN, {16'd0, len});
                cur_src  = src;
                cur_dst  = dst;
                cur_len  = int'(len);
                rd_count = 0;
                wr_count = 0;
                write_reg(gpu_pkg::REG_CTRL, 32'd1);
                while (!o_busy) @(posedge i_wire_clock);
                if (restart) begin
                        // second start lands mid copy
                        write_reg(gpu_pkg::REG_CTRL, 32'd1);
                        check_value({name, " busy at restart"}, 32'd1, {31'd0, o_busy});
                end
                cycles = 0;
                while (!o_done) begin
                        @(posedge i_wire_clock);
                        cycles++;
                end
                if (len == '0) begin
                        check_value({name, " done delay"}, 32'd2, cycles);
                end
                check_value({name, " reads"}, {16'd0, len}, rd_count);
                check_value({name, " writes"}, {16'd0, len}, wr_count);
                src_idx = int'(src[9:2]);
                dst_idx = int'(dst[9:2]);
                for (int i = 0; i < int'(len); i++) begin
                        check_value($sformatf("%s word %0d", name, i), mem[src_idx + i],
                                    mem[dst_idx + i]);
                end
                check_value({name, " word below"}, fill_word(dst_idx - 1), mem[dst_idx - 1]);
                check_value({name, " word above"}, fill_word(dst_idx + int'(len)),
                            mem[dst_idx + int'(len)]);
                check_reg({name, " status"}, gpu_pkg::REG_STATUS, 32'h2);
                repeat (4) @(posedge i_wire_clock);
                check_value({name, " idle after done"}, 32'd0, {31'd0, o_busy});
        endtask

        initial begin
                void'($urandom(43));
                i_rst       = 1'b1;
                i_reg_write = 1'b0;
                i_reg_addr  = '0;
                i_reg_wdata = '0;
                // random source words in the low quarter, address pattern elsewhere
                for (int i = 0; i < MEM_WORDS; i++) begin
                        mem[i] = (i < 64) ? $urandom() : fill_word(i);
                end
                repeat (4) @(posedge i_wire_clock);
                i_rst <= 1'b0;
                @(negedge i_wire_clock);
                check_value("reset o_busy", 32'd0, {31'd0, o_busy});
                check_value("reset o_done", 32'd0, {31'd0, o_done});
                check_value("reset o_mem_rd_req", 32'd0, {31'd0, o_mem_rd_req});
                check_value("reset o_mem_wr_en", 32'd0, {31'd0, o_mem_wr_en});
                run_copy("copy_1", 32'h040, 32'h300, 16'd1, 1'b0);
                run_copy("copy_13", 32'h080, 32'h200, 16'd13, 1'b1);
                run_copy("copy_0", 32'h100, 32'h380, 16'd0, 1'b0);
                finish_run(1'b0);
        end

        // watchdog
        initial begin : watchdog
                int cycle;
                for (cycle = 0; cycle < MAX_CYCLES; cycle++) begin
                        @(posedge i_wire_clock);
                end
                $display("timeout: run still going after %0d cycles", MAX_CYCLES);
                finish_run(1'b1);
        end

endmodule

/* flist.f */
hdl/gpu_pkg.sv
hdl/gpu_controller.sv
hdl/gpu_memcpy.sv
hdl/gpu_dma_reader.sv
hdl/gpu_fifo.sv
hdl/gpu_dma_writer.sv
hdl/gpu_top.sv
verif/gpu_properties.sv
verif/tb_gpu.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_gpu -f flist.f

# the simulation result comes from its own output
output=$(./obj_dir/Vtb_gpu +verilator+error+limit+1000) || true
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
        exit 0
fi
exit 1
